// ==== src/cps_video_pkg.sv ====
`default_nettype none

package cps_video_pkg;

    // configuration chain length in bytes
    localparam int CFG_BYTES = 16;

    localparam logic [15:0] PRIO_RESET     = 16'hffff;
    localparam logic [5:0]  PAL_PAGE_RESET = 6'h3f;
    localparam logic [15:0] OPEN_BUS       = 16'hffff;

    // addr is the word address, i.e. cpu byte address bits 5:1
    typedef struct packed {
        logic [4:0]  addr;
        logic [1:0]  dsn;
        logic [15:0] data;
    } cpu_bus_t;

    typedef struct packed {
        logic [15:0] hpos1;
        logic [15:0] vpos1;
        logic [15:0] hpos2;
        logic [15:0] vpos2;
        logic [15:0] hpos3;
        logic [15:0] vpos3;
        logic [15:0] hstar1;
        logic [15:0] vstar1;
        logic [15:0] hstar2;
        logic [15:0] vstar2;
    } scroll_regs_t;

    typedef struct packed {
        logic [15:0] obj;
        logic [15:0] scr1;
        logic [15:0] scr2;
        logic [15:0] scr3;
        logic [15:0] row;
        logic [15:0] star;
        logic [15:0] pal;
    } vram_base_t;

    typedef struct packed {
        logic [15:0] layer_ctrl;
        logic [15:0] prio0;
        logic [15:0] prio1;
        logic [15:0] prio2;
        logic [15:0] prio3;
        logic [5:0]  pal_page_en;
        logic [7:0]  mask0;
        logic [7:0]  mask1;
        logic [7:0]  mask2;
        logic [7:0]  mask3;
    } layer_cfg_t;

    // chain slots: 0 id, 1 chip_id, 2 mult1, 3 mult2, 4 rslt0, 5 rslt1,
    // 6 layer, 7..10 prio0..prio3, 11 pal_page, 12..15 mask0..mask3
    typedef struct packed {
        logic [4:0] id;
        logic [4:0] mult1;
        logic [4:0] mult2;
        logic [4:0] rslt0;
        logic [4:0] rslt1;
        logic [4:0] layer;
        logic [4:0] prio0;
        logic [4:0] prio1;
        logic [4:0] prio2;
        logic [4:0] prio3;
        logic [4:0] pal_page;
        logic [7:0] chip_id;
        logic [7:0] mask0;
        logic [7:0] mask1;
        logic [7:0] mask2;
        logic [7:0] mask3;
    } cpsb_map_t;

    typedef enum logic [4:0] {
        CPSA_OBJ      = 5'h00,
        CPSA_SCR1     = 5'h01,
        CPSA_SCR2     = 5'h02,
        CPSA_SCR3     = 5'h03,
        CPSA_ROW      = 5'h04,
        CPSA_PAL      = 5'h05,
        CPSA_HPOS1    = 5'h06,
        CPSA_VPOS1    = 5'h07,
        CPSA_HPOS2    = 5'h08,
        CPSA_VPOS2    = 5'h09,
        CPSA_HPOS3    = 5'h0a,
        CPSA_VPOS3    = 5'h0b,
        CPSA_HSTAR1   = 5'h0c,
        CPSA_VSTAR1   = 5'h0d,
        CPSA_HSTAR2   = 5'h0e,
        CPSA_VSTAR2   = 5'h0f,
        CPSA_STAR     = 5'h10,
        CPSA_PPU_CTRL = 5'h11
    } cpsa_reg_e;

    // value minus one is the role index in match priority order
    typedef enum logic [3:0] {
        SEL_NONE     = 4'd0,
        SEL_ID       = 4'd1,
        SEL_MULT1    = 4'd2,
        SEL_MULT2    = 4'd3,
        SEL_RSLT0    = 4'd4,
        SEL_RSLT1    = 4'd5,
        SEL_LAYER    = 4'd6,
        SEL_PRIO0    = 4'd7,
        SEL_PRIO1    = 4'd8,
        SEL_PRIO2    = 4'd9,
        SEL_PRIO3    = 4'd10,
        SEL_PAL_PAGE = 4'd11
    } cpsb_sel_e;

endpackage

`default_nettype wire

// ==== src/cpsb_cfg_chain.sv ====
`default_nettype none

module cpsb_cfg_chain (
    input  logic                     clk,
    input  logic                     reg_rst,
    input  logic                     cfg_we,
    input  logic [7:0]               cfg_data,
    output cps_video_pkg::cpsb_map_t map
);

    // slot 0 holds the newest byte
    logic [cps_video_pkg::CFG_BYTES-1:0][7:0] chain;

    always_ff @(posedge clk or posedge reg_rst) begin
        if (reg_rst) begin
            chain <= '0;
        end else if (cfg_we) begin
            chain <= {chain[cps_video_pkg::CFG_BYTES-2:0], cfg_data};
        end
    end

    // byte addresses become word addresses by dropping bit 0
    always_comb begin
        map.id       = chain[0][5:1];
        map.mult1    = chain[2][5:1];
        map.mult2    = chain[3][5:1];
        map.rslt0    = chain[4][5:1];
        map.rslt1    = chain[5][5:1];
        map.layer    = chain[6][5:1];
        map.prio0    = chain[7][5:1];
        map.prio1    = chain[8][5:1];
        map.prio2    = chain[9][5:1];
        map.prio3    = chain[10][5:1];
        map.pal_page = chain[11][5:1];
        // 16-bit ID squeezed into one byte, widened on read
        map.chip_id  = chain[1];
        map.mask0    = chain[12];
        map.mask1    = chain[13];
        map.mask2    = chain[14];
        map.mask3    = chain[15];
    end

    // an X shifted in here would poison the address map for good
    a_cfg_data_known: assert property (
        @(posedge clk) disable iff (reg_rst)
        cfg_we |-> !$isunknown(cfg_data)
    );

endmodule

`default_nettype wire

// ==== src/cpsa_regs.sv ====
`default_nettype none

module cpsa_regs (
    input  logic                        clk,
    input  logic                        reg_rst,
    input  logic                        ppu1_cs,
    input  cps_video_pkg::cpu_bus_t     bus,
    output cps_video_pkg::scroll_regs_t scroll,
    output cps_video_pkg::vram_base_t   vram,
    output logic [15:0]                 ppu_ctrl,
    output logic                        pal_copy
);

    cps_video_pkg::cpsa_reg_e reg_sel;
    logic                     pal_pend;

    // keep the old byte wherever the lane strobe is inactive
    function automatic logic [15:0] lane_merge(
        input logic [15:0] old_val,
        input logic [15:0] new_val,
        input logic [1:0]  dsn
    );
        logic [15:0] merged;
        merged[15:8] = dsn[1] ? old_val[15:8] : new_val[15:8];
        merged[7:0]  = dsn[0] ? old_val[7:0]  : new_val[7:0];
        return merged;
    endfunction

    assign reg_sel = cps_video_pkg::cpsa_reg_e'(bus.addr);

    always_ff @(posedge clk or posedge reg_rst) begin
        if (reg_rst) begin
            scroll   <= '0;
            vram     <= '0;
            ppu_ctrl <= '0;
        end else if (ppu1_cs) begin
            case (reg_sel)
                cps_video_pkg::CPSA_OBJ:    vram.obj  <= lane_merge(vram.obj, bus.data, bus.dsn);
                cps_video_pkg::CPSA_SCR1:   vram.scr1 <= lane_merge(vram.scr1, bus.data, bus.dsn);
                cps_video_pkg::CPSA_SCR2:   vram.scr2 <= lane_merge(vram.scr2, bus.data, bus.dsn);
                cps_video_pkg::CPSA_SCR3:   vram.scr3 <= lane_merge(vram.scr3, bus.data, bus.dsn);
                cps_video_pkg::CPSA_ROW:    vram.row  <= lane_merge(vram.row, bus.data, bus.dsn);
                cps_video_pkg::CPSA_PAL:    vram.pal  <= lane_merge(vram.pal, bus.data, bus.dsn);
                cps_video_pkg::CPSA_HPOS1: begin
                    scroll.hpos1 <= lane_merge(scroll.hpos1, bus.data, bus.dsn);
                end
                cps_video_pkg::CPSA_VPOS1: begin
                    scroll.vpos1 <= lane_merge(scroll.vpos1, bus.data, bus.dsn);
                end
                cps_video_pkg::CPSA_HPOS2: begin
                    scroll.hpos2 <= lane_merge(scroll.hpos2, bus.data, bus.dsn);
                end
                cps_video_pkg::CPSA_VPOS2: begin
                    scroll.vpos2 <= lane_merge(scroll.vpos2, bus.data, bus.dsn);
                end
                cps_video_pkg::CPSA_HPOS3: begin
                    scroll.hpos3 <= lane_merge(scroll.hpos3, bus.data, bus.dsn);
                end
                cps_video_pkg::CPSA_VPOS3: begin
                    scroll.vpos3 <= lane_merge(scroll.vpos3, bus.data, bus.dsn);
                end
                cps_video_pkg::CPSA_HSTAR1: begin
                    scroll.hstar1 <= lane_merge(scroll.hstar1, bus.data, bus.dsn);
                end
                cps_video_pkg::CPSA_VSTAR1: begin
                    scroll.vstar1 <= lane_merge(scroll.vstar1, bus.data, bus.dsn);
                end
                cps_video_pkg::CPSA_HSTAR2: begin
                    scroll.hstar2 <= lane_merge(scroll.hstar2, bus.data, bus.dsn);
                end
                cps_video_pkg::CPSA_VSTAR2: begin
                    scroll.vstar2 <= lane_merge(scroll.vstar2, bus.data, bus.dsn);
                end
                cps_video_pkg::CPSA_STAR:   vram.star <= lane_merge(vram.star, bus.data, bus.dsn);
                cps_video_pkg::CPSA_PPU_CTRL: ppu_ctrl <= lane_merge(ppu_ctrl, bus.data, bus.dsn);
                default: begin
                end
            endcase
        end
    end

    // pal_base may still change while cs is high, so the copy waits for cs to drop
    always_ff @(posedge clk or posedge reg_rst) begin
        if (reg_rst) begin
            pal_pend <= 1'b0;
            pal_copy <= 1'b0;
        end else begin
            pal_copy <= 1'b0;
            if (ppu1_cs && reg_sel == cps_video_pkg::CPSA_PAL) begin
                pal_pend <= 1'b1;
            end else if (!ppu1_cs && pal_pend) begin
                pal_copy <= 1'b1;
                pal_pend <= 1'b0;
            end
        end
    end

    a_pal_copy_single: assert property (
        @(posedge clk) disable iff (reg_rst)
        pal_copy |=> !pal_copy
    );

    a_pal_copy_cs_low: assert property (
        @(posedge clk) disable iff (reg_rst)
        pal_copy |-> !ppu1_cs
    );

endmodule

`default_nettype wire

// ==== src/cpsb_regs.sv ====
`default_nettype none

module cpsb_regs (
    input  logic                      clk,
    input  logic                      reg_rst,
    input  logic                      ppu2_cs,
    input  logic                      ppu1_cs,
    input  cps_video_pkg::cpu_bus_t   bus,
    input  cps_video_pkg::cpsb_map_t  map,
    output cps_video_pkg::layer_cfg_t layer,
    output logic [15:0]               mmr_dout
);

    logic [10:0]               hit;
    cps_video_pkg::cpsb_sel_e  sel;
    logic                      wr_en;
    logic [15:0]               mult1;
    logic [15:0]               mult2;
    logic [31:0]               product;
    logic [15:0]               layer_ctrl;
    logic [3:0][15:0]          prio;
    logic [5:0]                pal_page_en;
    logic [15:0]               rd_val;

    // bit order follows the role order, bit 0 has top priority
    assign hit[0]  = (bus.addr == map.id);
    assign hit[1]  = (bus.addr == map.mult1);
    assign hit[2]  = (bus.addr == map.mult2);
    assign hit[3]  = (bus.addr == map.rslt0);
    assign hit[4]  = (bus.addr == map.rslt1);
    assign hit[5]  = (bus.addr == map.layer);
    assign hit[6]  = (bus.addr == map.prio0);
    assign hit[7]  = (bus.addr == map.prio1);
    assign hit[8]  = (bus.addr == map.prio2);
    assign hit[9]  = (bus.addr == map.prio3);
    assign hit[10] = (bus.addr == map.pal_page);

    // scan from the lowest priority up so the lowest role is left standing
    always_comb begin
        sel = cps_video_pkg::SEL_NONE;
        for (int i = 10; i >= 0; i--) begin
            if (hit[i]) begin
                sel = cps_video_pkg::cpsb_sel_e'(4'(i + 1));
            end
        end
    end

    // B registers only take full-word writes
    assign wr_en   = ppu2_cs && (bus.dsn == 2'b00);
    assign product = mult1 * mult2;

    always_ff @(posedge clk or posedge reg_rst) begin
        if (reg_rst) begin
            mult1       <= '0;
            mult2       <= '0;
            layer_ctrl  <= '0;
            prio        <= {4{cps_video_pkg::PRIO_RESET}};
            pal_page_en <= cps_video_pkg::PAL_PAGE_RESET;
        end else if (wr_en) begin
            case (sel)
                cps_video_pkg::SEL_MULT1:    mult1       <= bus.data;
                cps_video_pkg::SEL_MULT2:    mult2       <= bus.data;
                cps_video_pkg::SEL_LAYER:    layer_ctrl  <= bus.data;
                cps_video_pkg::SEL_PRIO0:    prio[0]     <= bus.data;
                cps_video_pkg::SEL_PRIO1:    prio[1]     <= bus.data;
                cps_video_pkg::SEL_PRIO2:    prio[2]     <= bus.data;
                cps_video_pkg::SEL_PRIO3:    prio[3]     <= bus.data;
                cps_video_pkg::SEL_PAL_PAGE: pal_page_en <= bus.data[5:0];
                default: begin
                end
            endcase
        end
    end

    always_comb begin
        case (sel)
            // chip ID nibbles each get their own byte
            cps_video_pkg::SEL_ID:       rd_val = {4'h0, map.chip_id[7:4], 4'h0, map.chip_id[3:0]};
            cps_video_pkg::SEL_MULT1:    rd_val = mult1;
            cps_video_pkg::SEL_MULT2:    rd_val = mult2;
            cps_video_pkg::SEL_RSLT0:    rd_val = product[15:0];
            cps_video_pkg::SEL_RSLT1:    rd_val = product[31:16];
            cps_video_pkg::SEL_LAYER:    rd_val = layer_ctrl;
            cps_video_pkg::SEL_PRIO0:    rd_val = prio[0];
            cps_video_pkg::SEL_PRIO1:    rd_val = prio[1];
            cps_video_pkg::SEL_PRIO2:    rd_val = prio[2];
            cps_video_pkg::SEL_PRIO3:    rd_val = prio[3];
            cps_video_pkg::SEL_PAL_PAGE: rd_val = {10'd0, pal_page_en};
            default:                     rd_val = cps_video_pkg::OPEN_BUS;
        endcase
    end

    always_ff @(posedge clk or posedge reg_rst) begin
        if (reg_rst) begin
            mmr_dout <= '0;
        end else if (ppu2_cs) begin
            mmr_dout <= rd_val;
        end
    end

    always_comb begin
        layer.layer_ctrl  = layer_ctrl;
        layer.prio0       = prio[0];
        layer.prio1       = prio[1];
        layer.prio2       = prio[2];
        layer.prio3       = prio[3];
        layer.pal_page_en = pal_page_en;
        // masks come straight from the configuration chain
        layer.mask0       = map.mask0;
        layer.mask1       = map.mask1;
        layer.mask2       = map.mask2;
        layer.mask3       = map.mask3;
    end

    // both chips share the data bus, only one may be selected
    a_cs_exclusive: assert property (
        @(posedge clk) disable iff (reg_rst)
        !(ppu1_cs && ppu2_cs)
    );

endmodule

`default_nettype wire

// ==== src/cps_video_regs.sv ====
`default_nettype none

module cps_video_regs (
    input  logic                        clk,
    input  logic                        reg_rst,
    input  logic                        ppu1_cs,
    input  logic                        ppu2_cs,
    input  cps_video_pkg::cpu_bus_t     bus,
    input  logic                        cfg_we,
    input  logic [7:0]                  cfg_data,
    output logic [15:0]                 mmr_dout,
    output logic [15:0]                 ppu_ctrl,
    output cps_video_pkg::scroll_regs_t scroll,
    output cps_video_pkg::vram_base_t   vram,
    output logic                        pal_copy,
    output cps_video_pkg::layer_cfg_t   layer
);

    // per-game address map for the B chip
    cps_video_pkg::cpsb_map_t cpsb_map;

    cpsb_cfg_chain i_cfg_chain (
        .clk      (clk),
        .reg_rst  (reg_rst),
        .cfg_we   (cfg_we),
        .cfg_data (cfg_data),
        .map      (cpsb_map)
    );

    // fixed map chip
    cpsa_regs i_cpsa_regs (
        .clk      (clk),
        .reg_rst  (reg_rst),
        .ppu1_cs  (ppu1_cs),
        .bus      (bus),
        .scroll   (scroll),
        .vram     (vram),
        .ppu_ctrl (ppu_ctrl),
        .pal_copy (pal_copy)
    );

    // configurable chip, ppu1_cs only feeds its select check
    cpsb_regs i_cpsb_regs (
        .clk      (clk),
        .reg_rst  (reg_rst),
        .ppu2_cs  (ppu2_cs),
        .ppu1_cs  (ppu1_cs),
        .bus      (bus),
        .map      (cpsb_map),
        .layer    (layer),
        .mmr_dout (mmr_dout)
    );

endmodule

`default_nettype wire

// ==== tests/tb_cps_video_regs.sv ====
`default_nettype none

module tb_cps_video_regs;

    logic                        clk;
    logic                        reg_rst;
    logic                        ppu1_cs;
    logic                        ppu2_cs;
    cps_video_pkg::cpu_bus_t     bus;
    logic                        cfg_we;
    logic [7:0]                  cfg_data;
    logic [15:0]                 mmr_dout;
    logic [15:0]                 ppu_ctrl;
    cps_video_pkg::scroll_regs_t scroll;
    cps_video_pkg::vram_base_t   vram;
    logic                        pal_copy;
    cps_video_pkg::layer_cfg_t   layer;

    // chain contents by slot, expected A registers, expected B registers by role
    logic [7:0]  cfg_bytes [16];
    logic [15:0] a_exp [18];
    logic [15:0] b_exp [11];
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          cycles = 0;

    cps_video_regs i_dut (
        .clk      (clk),
        .reg_rst  (reg_rst),
        .ppu1_cs  (ppu1_cs),
        .ppu2_cs  (ppu2_cs),
        .bus      (bus),
        .cfg_we   (cfg_we),
        .cfg_data (cfg_data),
        .mmr_dout (mmr_dout),
        .ppu_ctrl (ppu_ctrl),
        .scroll   (scroll),
        .vram     (vram),
        .pal_copy (pal_copy),
        .layer    (layer)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // whole run needs a few hundred cycles
    always @(posedge clk) begin
        cycles++;
        if (cycles >= 2000) begin
            $display("timeout: tests did not finish within 2000 cycles");
            $display("=== FAIL ===");
            $finish;
        end
    end

    task automatic check_val(input string name, input logic [159:0] got,
                             input logic [159:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("FAIL %s got %0h expected %0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests++;
        if (errors == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - errs_before);
        end
    endtask

    task automatic a_write(input logic [4:0] addr, input logic [1:0] dsn,
                           input logic [15:0] data);
        @(posedge clk);
        bus <= {addr, dsn, data};
        ppu1_cs <= 1'b1;
        @(posedge clk);
        ppu1_cs <= 1'b0;
        // bus idles for a cycle so a palette copy pulse sees cs low
        @(posedge clk);
        @(negedge clk);
    endtask

    // one selected cycle, reads use dsn 2'b11 so nothing is written
    task automatic b_cycle(input logic [4:0] addr, input logic [1:0] dsn,
                           input logic [15:0] data);
        @(posedge clk);
        bus <= {addr, dsn, data};
        ppu2_cs <= 1'b1;
        @(posedge clk);
        ppu2_cs <= 1'b0;
        @(negedge clk);
    endtask

    // first byte sent ends up in slot 15
    task automatic load_chain();
        for (int s = 15; s >= 0; s--) begin
            @(posedge clk);
            cfg_we <= 1'b1;
            cfg_data <= cfg_bytes[s];
        end
        @(posedge clk);
        cfg_we <= 1'b0;
        @(negedge clk);
    endtask

    // role 0 is id in slot 0, the other roles skip the chip ID slot
    function automatic logic [4:0] role_addr(input int role);
        int slot;
        slot = (role == 0) ? 0 : role + 1;
        return cfg_bytes[slot][5:1];
    endfunction

    function automatic logic [15:0] a_field(input int off);
        case (off)
            0:       return vram.obj;
            1:       return vram.scr1;
            2:       return vram.scr2;
            3:       return vram.scr3;
            4:       return vram.row;
            5:       return vram.pal;
            6:       return scroll.hpos1;
            7:       return scroll.vpos1;
            8:       return scroll.hpos2;
            9:       return scroll.vpos2;
            10:      return scroll.hpos3;
            11:      return scroll.vpos3;
            12:      return scroll.hstar1;
            13:      return scroll.vstar1;
            14:      return scroll.hstar2;
            15:      return scroll.vstar2;
            16:      return vram.star;
            default: return ppu_ctrl;
        endcase
    endfunction

    task automatic test_reset();
        int e0;
        e0 = errors;
        check_val("scroll", scroll, '0);
        check_val("vram", vram, '0);
        check_val("ppu_ctrl", ppu_ctrl, 16'h0);
        check_val("mmr_dout", mmr_dout, 16'h0);
        check_val("layer.layer_ctrl", layer.layer_ctrl, 16'h0);
        check_val("layer.prio0", layer.prio0, 16'hffff);
        check_val("layer.prio1", layer.prio1, 16'hffff);
        check_val("layer.prio2", layer.prio2, 16'hffff);
        check_val("layer.prio3", layer.prio3, 16'hffff);
        check_val("layer.pal_page_en", layer.pal_page_en, 6'h3f);
        check_val("layer masks", {layer.mask0, layer.mask1, layer.mask2, layer.mask3}, 32'h0);
        repeat (4) begin
            @(negedge clk);
            check_val("pal_copy", pal_copy, 1'b0);
        end
        report_test("reset", e0);
    endtask

    task automatic test_a_writes();
        int          e0;
        logic [15:0] v;
        e0 = errors;
        for (int off = 0; off < 18; off++) begin
            v = 16'($urandom);
            a_write(5'(off), 2'b00, v);
            a_exp[off] = v;
            check_val($sformatf("cpsa reg %02h", off), a_field(off), v);
        end
        // upper lane only, dsn is active low
        v = 16'($urandom);
        a_write(5'h03, 2'b01, v);
        a_exp[3] = {v[15:8], a_exp[3][7:0]};
        v = 16'($urandom);
        a_write(5'h0a, 2'b10, v);
        a_exp[10] = {a_exp[10][15:8], v[7:0]};
        // bus active but chip not selected
        @(posedge clk);
        bus <= {5'h11, 2'b00, ~a_exp[17]};
        @(posedge clk);
        @(negedge clk);
        for (int off = 0; off < 18; off++) begin
            check_val($sformatf("cpsa reg %02h", off), a_field(off), a_exp[off]);
        end
        report_test("cpsa writes", e0);
    endtask

    task automatic test_pal_copy();
        int          e0;
        logic [15:0] v;
        e0 = errors;
        v = 16'($urandom);
        @(posedge clk);
        bus <= {5'h05, 2'b00, v};
        ppu1_cs <= 1'b1;
        // three edges with cs high, dropped on the last one
        for (int i = 0; i < 3; i++) begin
            @(posedge clk);
            if (i == 2) begin
                ppu1_cs <= 1'b0;
            end
            @(negedge clk);
            check_val("pal_copy", pal_copy, 1'b0);
        end
        @(negedge clk);
        check_val("pal_copy", pal_copy, 1'b1);
        check_val("vram.pal", vram.pal, v);
        repeat (3) begin
            @(negedge clk);
            check_val("pal_copy", pal_copy, 1'b0);
        end
        report_test("palette copy", e0);
    endtask

    task automatic test_config();
        int e0;
        e0 = errors;
        load_chain();
        check_val("layer.mask0", layer.mask0, cfg_bytes[12]);
        check_val("layer.mask1", layer.mask1, cfg_bytes[13]);
        check_val("layer.mask2", layer.mask2, cfg_bytes[14]);
        check_val("layer.mask3", layer.mask3, cfg_bytes[15]);
        b_cycle(role_addr(0), 2'b11, 16'h0);
        check_val("mmr_dout id", mmr_dout, 16'h0a05);
        b_cycle(5'h1f, 2'b11, 16'h0);
        check_val("mmr_dout unmapped", mmr_dout, 16'hffff);
        report_test("configuration", e0);
    endtask

    task automatic test_b_regs();
        int          e0;
        logic [15:0] m1;
        logic [15:0] m2;
        logic [15:0] v;
        logic [31:0] prod;
        e0 = errors;
        m1 = 16'($urandom);
        m2 = 16'($urandom);
        prod = {16'h0, m1} * {16'h0, m2};
        b_cycle(role_addr(1), 2'b00, m1);
        b_cycle(role_addr(2), 2'b00, m2);
        b_cycle(role_addr(3), 2'b11, 16'h0);
        check_val("mmr_dout rslt0", mmr_dout, prod[15:0]);
        b_cycle(role_addr(4), 2'b11, 16'h0);
        check_val("mmr_dout rslt1", mmr_dout, prod[31:16]);
        // layer, prio0..prio3 and pal_page
        for (int r = 5; r <= 10; r++) begin
            v = 16'($urandom);
            b_cycle(role_addr(r), 2'b00, v);
            b_exp[r] = (r == 10) ? {10'd0, v[5:0]} : v;
            b_cycle(role_addr(r), 2'b11, 16'h0);
            check_val($sformatf("mmr_dout role %0d", r), mmr_dout, b_exp[r]);
        end
        check_val("layer.layer_ctrl", layer.layer_ctrl, b_exp[5]);
        check_val("layer.prio0", layer.prio0, b_exp[6]);
        check_val("layer.prio1", layer.prio1, b_exp[7]);
        check_val("layer.prio2", layer.prio2, b_exp[8]);
        check_val("layer.prio3", layer.prio3, b_exp[9]);
        check_val("layer.pal_page_en", layer.pal_page_en, b_exp[10][5:0]);
        // half-word writes are ignored
        b_cycle(role_addr(6), 2'b01, ~b_exp[6]);
        b_cycle(role_addr(6), 2'b10, ~b_exp[6]);
        check_val("layer.prio0", layer.prio0, b_exp[6]);
        report_test("cpsb registers", e0);
    endtask

    task automatic test_collision();
        int          e0;
        logic [15:0] v;
        e0 = errors;
        // prio1 slot takes the layer address
        cfg_bytes[8] = cfg_bytes[6];
        load_chain();
        v = ~b_exp[5];
        b_cycle(role_addr(5), 2'b00, v);
        check_val("layer.layer_ctrl", layer.layer_ctrl, v);
        check_val("layer.prio1", layer.prio1, b_exp[7]);
        b_cycle(role_addr(7), 2'b11, 16'h0);
        check_val("mmr_dout collision", mmr_dout, v);
        report_test("address collision", e0);
    endtask

    initial begin
        void'($urandom(30));
        reg_rst = 1'b1;
        ppu1_cs = 1'b0;
        ppu2_cs = 1'b0;
        bus = '0;
        cfg_we = 1'b0;
        cfg_data = 8'h00;
        // byte addresses, chip ID in slot 1, masks in slots 12..15
        cfg_bytes = '{8'h32, 8'ha5, 8'h00, 8'h02, 8'h04, 8'h06, 8'h26, 8'h28,
                      8'h2a, 8'h2c, 8'h2e, 8'h30, 8'h3c, 8'hc3, 8'h5a, 8'h96};
        repeat (10) @(posedge clk);
        reg_rst <= 1'b0;
        @(negedge clk);
        test_reset();
        test_a_writes();
        test_pal_copy();
        test_config();
        test_b_regs();
        test_collision();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
src/cps_video_pkg.sv
src/cpsb_cfg_chain.sv
src/cpsa_regs.sv
src/cpsb_regs.sv
src/cps_video_regs.sv
tests/tb_cps_video_regs.sv
